// File: source/pwm_led_pkg.sv
package pwm_led_pkg;

	////////////////////
	// Widths
	////////////////////

	// SoC bus
	localparam int DATA_BITS = 16;
	localparam int ADDR_BITS = 8;

	// Duty and counter resolution
	localparam int PWM_BITS = 8;

	typedef logic [DATA_BITS-1:0] data_t;
	typedef logic [ADDR_BITS-1:0] addr_t;
	typedef logic [PWM_BITS-1:0]  duty_t;

	////////////////////
	// Register map
	////////////////////

	localparam addr_t ADDR_RED   = 8'h00;
	localparam addr_t ADDR_GREEN = 8'h01;
	localparam addr_t ADDR_BLUE  = 8'h02;
	localparam addr_t ADDR_CTRL  = 8'h03;

	// Control word layout
	localparam int CTRL_EN_BIT = 0;

	// Values after reset
	localparam duty_t DUTY_RST = '0;
	localparam logic  EN_RST   = 1'b1;

	////////////////////
	// Read source
	////////////////////

	typedef enum logic [2:0] {
		RD_RED,
		RD_GREEN,
		RD_BLUE,
		RD_CTRL,
		RD_NONE
	} rd_sel_t;

endpackage

// File: source/pwm_wr_if.sv
`timescale 1ns/100ps

interface pwm_wr_if
	import pwm_led_pkg::*;
();

	// One-hot register write strobes
	logic  wr_red;
	logic  wr_green;
	logic  wr_blue;
	logic  wr_ctrl;

	// Raw bus word of the write
	data_t wdata;

	modport dec (
		output wr_red,
		output wr_green,
		output wr_blue,
		output wr_ctrl,
		output wdata
	);

	modport exe (
		input  wr_red,
		input  wr_green,
		input  wr_blue,
		input  wr_ctrl,
		input  wdata
	);

endinterface

// File: source/pwm_state_if.sv
`timescale 1ns/100ps

interface pwm_state_if
	import pwm_led_pkg::*;
();

	// Live register values
	duty_t red_duty;
	duty_t green_duty;
	duty_t blue_duty;
	logic  enable;

	// Registered comparator outputs
	logic  lvl_r;
	logic  lvl_g;
	logic  lvl_b;

	modport exe (
		output red_duty,
		output green_duty,
		output blue_duty,
		output enable,
		output lvl_r,
		output lvl_g,
		output lvl_b
	);

	modport res (
		input  red_duty,
		input  green_duty,
		input  blue_duty,
		input  enable,
		input  lvl_r,
		input  lvl_g,
		input  lvl_b
	);

endinterface

// File: source/pwm_reg_decode.sv
`timescale 1ns/100ps

module pwm_reg_decode
	import pwm_led_pkg::*;
(
	input  logic    CLK,
	input  logic    RSTb,
	input  addr_t   ADDRESS,
	input  logic    WR,
	input  data_t   DATA_IN,
	pwm_wr_if.dec   wr,
	output rd_sel_t rd_sel
);

	rd_sel_t addr_sel;

	////////////////////
	// Address match
	////////////////////

	// Single compare against the map, shared by reads and writes
	always_comb begin
		case (ADDRESS)
			ADDR_RED: begin
				addr_sel = RD_RED;
			end
			ADDR_GREEN: begin
				addr_sel = RD_GREEN;
			end
			ADDR_BLUE: begin
				addr_sel = RD_BLUE;
			end
			ADDR_CTRL: begin
				addr_sel = RD_CTRL;
			end
			default: begin
				addr_sel = RD_NONE;
			end
		endcase
	end

	////////////////////
	// Write strobes
	////////////////////

	always_comb begin
		wr.wr_red   = 1'b0;
		wr.wr_green = 1'b0;
		wr.wr_blue  = 1'b0;
		wr.wr_ctrl  = 1'b0;
		if (WR) begin
			case (addr_sel)
				RD_RED:   wr.wr_red   = 1'b1;
				RD_GREEN: wr.wr_green = 1'b1;
				RD_BLUE:  wr.wr_blue  = 1'b1;
				RD_CTRL:  wr.wr_ctrl  = 1'b1;
				default:  ;
			endcase
		end
	end

	assign wr.wdata = DATA_IN;

	// Read select follows the address every cycle
	assign rd_sel = addr_sel;

endmodule

// File: source/pwm_channels.sv
`timescale 1ns/100ps

module pwm_channels
	import pwm_led_pkg::*;
(
	input  logic     CLK,
	input  logic     RSTb,
	pwm_wr_if.exe    wr,
	pwm_state_if.exe st
);

	duty_t red_duty;
	duty_t green_duty;
	duty_t blue_duty;
	logic  enable;

	duty_t wr_duty;

	// Free-running, starts at zero and is never reset
	duty_t pwm_ctr = '0;

	logic  lvl_r;
	logic  lvl_g;
	logic  lvl_b;

	////////////////////
	// Registers
	////////////////////

	// Duty takes the low byte of the bus word
	assign wr_duty = wr.wdata[PWM_BITS-1:0];

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			red_duty   <= DUTY_RST;
			green_duty <= DUTY_RST;
			blue_duty  <= DUTY_RST;
			enable     <= EN_RST;
		end else begin
			if (wr.wr_red) begin
				red_duty <= wr_duty;
			end
			if (wr.wr_green) begin
				green_duty <= wr_duty;
			end
			if (wr.wr_blue) begin
				blue_duty <= wr_duty;
			end
			if (wr.wr_ctrl) begin
				enable <= wr.wdata[CTRL_EN_BIT];
			end
		end
	end

	////////////////////
	// PWM counter
	////////////////////

	// Wraps every 2**PWM_BITS cycles
	always_ff @(posedge CLK) begin
		pwm_ctr <= pwm_ctr + 1'b1;
	end

	////////////////////
	// Comparators
	////////////////////

	// High for exactly duty counts out of each period
	always_ff @(posedge CLK) begin
		lvl_r <= (pwm_ctr < red_duty);
		lvl_g <= (pwm_ctr < green_duty);
		lvl_b <= (pwm_ctr < blue_duty);
	end

	////////////////////
	// State out
	////////////////////

	assign st.red_duty   = red_duty;
	assign st.green_duty = green_duty;
	assign st.blue_duty  = blue_duty;
	assign st.enable     = enable;

	assign st.lvl_r = lvl_r;
	assign st.lvl_g = lvl_g;
	assign st.lvl_b = lvl_b;

endmodule

// File: source/pwm_led_output.sv
`timescale 1ns/100ps

module pwm_led_output
	import pwm_led_pkg::*;
(
	input  logic     CLK,
	input  logic     RSTb,
	pwm_state_if.res st,
	input  rd_sel_t  rd_sel,
	output data_t    DATA_OUT,
	output logic     r,
	output logic     g,
	output logic     b
);

	localparam int PAD_BITS = DATA_BITS - PWM_BITS;

	data_t rd_word;

	////////////////////
	// Pins
	////////////////////

	// Levels gated by enable, one more register stage
	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			r <= 1'b0;
			g <= 1'b0;
			b <= 1'b0;
		end else begin
			r <= st.lvl_r & st.enable;
			g <= st.lvl_g & st.enable;
			b <= st.lvl_b & st.enable;
		end
	end

	////////////////////
	// Readback
	////////////////////

	always_comb begin
		rd_word = '0;
		case (rd_sel)
			RD_RED: begin
				rd_word = {{PAD_BITS{1'b0}}, st.red_duty};
			end
			RD_GREEN: begin
				rd_word = {{PAD_BITS{1'b0}}, st.green_duty};
			end
			RD_BLUE: begin
				rd_word = {{PAD_BITS{1'b0}}, st.blue_duty};
			end
			RD_CTRL: begin
				rd_word[CTRL_EN_BIT] = st.enable;
			end
			default: begin
				// unmapped address reads zero
				rd_word = '0;
			end
		endcase
	end

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			DATA_OUT <= '0;
		end else begin
			DATA_OUT <= rd_word;
		end
	end

endmodule

// File: source/pwm_led.sv
`timescale 1ns/100ps

module pwm_led
	import pwm_led_pkg::*;
(
	input  logic  CLK,
	input  logic  RSTb,
	input  addr_t ADDRESS,
	input  data_t DATA_IN,
	input  logic  WR,
	output data_t DATA_OUT,
	output logic  r,
	output logic  g,
	output logic  b
);

	// Decode to channels
	pwm_wr_if    wr_bus ();

	// Channels to output stage
	pwm_state_if st_bus ();

	rd_sel_t rd_sel;

	////////////////////
	// Decode
	////////////////////

	pwm_reg_decode dec0 (
		.CLK     (CLK),
		.RSTb    (RSTb),
		.ADDRESS (ADDRESS),
		.WR      (WR),
		.DATA_IN (DATA_IN),
		.wr      (wr_bus.dec),
		.rd_sel  (rd_sel)
	);

	////////////////////
	// Execute
	////////////////////

	pwm_channels chan0 (
		.CLK  (CLK),
		.RSTb (RSTb),
		.wr   (wr_bus.exe),
		.st   (st_bus.exe)
	);

	////////////////////
	// Result
	////////////////////

	pwm_led_output out0 (
		.CLK      (CLK),
		.RSTb     (RSTb),
		.st       (st_bus.res),
		.rd_sel   (rd_sel),
		.DATA_OUT (DATA_OUT),
		.r        (r),
		.g        (g),
		.b        (b)
	);

endmodule

// File: bench/clk_gen.sv
`timescale 1ns/100ps

module clk_gen (
	output logic CLK,
	output logic RSTb
);

	localparam int HALF_PERIOD_NS = 50;
	localparam int RST_CYCLES     = 2;

	initial begin
		CLK = 1'b0;
		forever #(HALF_PERIOD_NS) CLK = ~CLK;
	end

	// Release lines up with the stimulus point after the edge
	initial begin
		RSTb = 1'b0;
		repeat (RST_CYCLES) @(posedge CLK);
		#10;
		RSTb = 1'b1;
	end

endmodule

// File: bench/pwm_led_chk.sv
`timescale 1ns/100ps

module pwm_led_chk
	import pwm_led_pkg::*;
(
	input logic  CLK,
	input logic  RSTb,
	input addr_t ADDRESS,
	input data_t DATA_OUT,
	input logic  enable,
	input logic  r,
	input logic  g,
	input logic  b
);

	// Pins drop one cycle after enable goes low
	pins_off_when_disabled: assert property (
		@(posedge CLK) disable iff (!RSTb)
		!enable |=> (!r && !g && !b)
	) else $error("LED pin high in the cycle after enable was low");

	// Anything above the control register reads zero
	unmapped_reads_zero: assert property (
		@(posedge CLK) disable iff (!RSTb)
		(ADDRESS > ADDR_CTRL) |=> (DATA_OUT == '0)
	) else $error("DATA_OUT not zero after an unmapped address");

	outputs_known: assert property (
		@(posedge CLK)
		RSTb |-> !$isunknown({r, g, b, DATA_OUT})
	) else $error("LED pins or DATA_OUT unknown after reset");

endmodule

bind pwm_led pwm_led_chk chk0 (
	.CLK      (CLK),
	.RSTb     (RSTb),
	.ADDRESS  (ADDRESS),
	.DATA_OUT (DATA_OUT),
	.enable   (st_bus.enable),
	.r        (r),
	.g        (g),
	.b        (b)
);

// File: bench/pwm_led_tb.sv
`timescale 1ns/100ps

module pwm_led_tb
	import pwm_led_pkg::*;
();

	localparam int CLK_PERIOD_NS   = 100;
	localparam int PERIOD_CYCLES   = 1 << PWM_BITS;
	localparam int N_TESTS         = 6;
	localparam int WATCHDOG_CYCLES = N_TESTS * 8 * PERIOD_CYCLES + 1000;

	logic  CLK;
	logic  RSTb;
	logic  rstb_por;
	logic  rstb_sw;
	addr_t ADDRESS;
	data_t DATA_IN;
	logic  WR;
	data_t DATA_OUT;
	logic  r;
	logic  g;
	logic  b;

	// Reference model of the register file
	duty_t exp_duty [3];
	logic  exp_en;
	addr_t reg_addr [3] = '{ADDR_RED, ADDR_GREEN, ADDR_BLUE};
	string color_name [3] = '{"red", "green", "blue"};

	int          hi_cnt [3];
	int          checks = 0;
	int          errors = 0;
	logic [31:0] seed = 32'hf05f_c77a;

	clk_gen clk_gen0 (
		.CLK  (CLK),
		.RSTb (rstb_por)
	);

	assign RSTb = rstb_por & rstb_sw;

	pwm_led dut0 (
		.CLK      (CLK),
		.RSTb     (RSTb),
		.ADDRESS  (ADDRESS),
		.DATA_IN  (DATA_IN),
		.WR       (WR),
		.DATA_OUT (DATA_OUT),
		.r        (r),
		.g        (g),
		.b        (b)
	);

	////////////////////
	// Helpers
	////////////////////

	function automatic logic [31:0] next_rand();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	task automatic next_cycle();
		@(posedge CLK);
		#10;
	endtask

	task automatic expect_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("[FAIL] %0t: %s is %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic bus_write(input addr_t a, input data_t d);
		ADDRESS = a;
		DATA_IN = d;
		WR      = 1'b1;
		next_cycle();
		WR      = 1'b0;
	endtask

	// One cycle of latency on the readback
	task automatic bus_read(input addr_t a, output data_t d);
		ADDRESS = a;
		WR      = 1'b0;
		next_cycle();
		d = DATA_OUT;
	endtask

	task automatic write_duty(input int idx, input data_t d);
		bus_write(reg_addr[idx], d);
		exp_duty[idx] = d[PWM_BITS-1:0];
	endtask

	task automatic write_ctrl(input data_t d);
		bus_write(ADDR_CTRL, d);
		exp_en = d[CTRL_EN_BIT];
	endtask

	task automatic wait_periods(input int n);
		repeat (n * PERIOD_CYCLES) next_cycle();
	endtask

	task automatic check_regs(input string tag);
		data_t got;
		for (int i = 0; i < 3; i++) begin
			bus_read(reg_addr[i], got);
			expect_eq({tag, " ", color_name[i], " duty"}, got, data_t'(exp_duty[i]));
		end
		bus_read(ADDR_CTRL, got);
		expect_eq({tag, " control"}, got, data_t'(exp_en));
	endtask

	// High cycles per pin over one PWM period
	task automatic check_counts(input string tag);
		hi_cnt = '{0, 0, 0};
		repeat (PERIOD_CYCLES) begin
			next_cycle();
			hi_cnt[0] += int'(r);
			hi_cnt[1] += int'(g);
			hi_cnt[2] += int'(b);
		end
		for (int i = 0; i < 3; i++) begin
			expect_eq({tag, " ", color_name[i], " high cycles"}, hi_cnt[i],
				exp_en ? 32'(exp_duty[i]) : 32'd0);
		end
	endtask

	////////////////////
	// Tests
	////////////////////

	// Duties clear and the dimmer comes up enabled
	task automatic check_reset_state();
		exp_duty = '{8'd0, 8'd0, 8'd0};
		exp_en   = 1'b1;
		check_regs("reset");
		check_counts("reset");
	endtask

	task automatic write_readback();
		for (int i = 0; i < 3; i++) begin
			write_duty(i, data_t'(next_rand()));
			check_regs({"after ", color_name[i], " write"});
		end
	endtask

	task automatic duty_counts();
		for (int i = 0; i < 3; i++) begin
			write_duty(i, data_t'(next_rand()));
		end
		wait_periods(2);
		check_counts("random duty");
		// Both ends of the range, upper bus bits as noise
		write_duty(0, 16'h5a00);
		write_duty(1, 16'hc3ff);
		write_duty(2, data_t'(next_rand()));
		wait_periods(2);
		check_counts("edge duty");
	endtask

	task automatic enable_gating();
		write_ctrl(16'hfffe);
		check_regs("disabled");
		check_counts("disabled");
		write_ctrl(16'h0001);
		wait_periods(2);
		check_counts("enabled again");
	endtask

	task automatic unmapped_access();
		addr_t a;
		data_t got;
		repeat (8) begin
			a = addr_t'(next_rand());
			if (a <= ADDR_CTRL) begin
				a = a + addr_t'(4);
			end
			bus_write(a, data_t'(next_rand()));
			bus_read(a, got);
			expect_eq($sformatf("read of unmapped 0x%02h", a), got, 32'd0);
		end
		check_regs("after unmapped writes");
	endtask

	task automatic mid_run_reset();
		rstb_sw = 1'b0;
		repeat (2) next_cycle();
		rstb_sw = 1'b1;
		check_reset_state();
	endtask

	////////////////////
	// Main
	////////////////////

	initial begin
		ADDRESS = '0;
		DATA_IN = '0;
		WR      = 1'b0;
		rstb_sw = 1'b1;
		wait (rstb_por === 1'b1);
		check_reset_state();
		write_readback();
		duty_counts();
		enable_gating();
		unmapped_access();
		mid_run_reset();
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD_NS);
		$display("Timeout: tests still running after %0d cycles", WATCHDOG_CYCLES);
		$display("Some tests failed");
		$finish;
	end

endmodule

// File: files.f
source/pwm_led_pkg.sv
source/pwm_wr_if.sv
source/pwm_state_if.sv
source/pwm_reg_decode.sv
source/pwm_channels.sv
source/pwm_led_output.sv
source/pwm_led.sv
bench/clk_gen.sv
bench/pwm_led_chk.sv
bench/pwm_led_tb.sv

// File: Bender.yml
package:
  name: pwm_led

dependencies: {}

sources:
  # RTL, in compile order
  - files:
      - source/pwm_led_pkg.sv
      - source/pwm_wr_if.sv
      - source/pwm_state_if.sv
      - source/pwm_reg_decode.sv
      - source/pwm_channels.sv
      - source/pwm_led_output.sv
      - source/pwm_led.sv

  # Testbench
  - target: simulation
    files:
      - bench/clk_gen.sv
      - bench/pwm_led_chk.sv
      - bench/pwm_led_tb.sv
